// File: src/muldiv_pkg.sv
//------------------------------
// muldiv package
// widths, function codes and the stream payloads of the mul/div unit
//------------------------------
`default_nettype none

package muldiv_pkg;

  // operand and tag widths
  localparam int data_width   = 32;
  localparam int tag_width    = 4;
  // 5 bits walk 31 down to 0, one value per step
  localparam int count_width  = 5;
  // full product, or remainder over quotient
  localparam int result_width = 2 * data_width;
  // divider working registers carry one guard bit for the sign of the difference
  localparam int div_reg_width = 2 * data_width + 1;

  // function codes, code 3 falls through to unsigned division
  typedef enum logic [1:0] {
    fn_mul          = 2'd0,
    fn_div_signed   = 2'd1,
    fn_div_unsigned = 2'd2
  } muldiv_fn_e;

  // iterative engine FSM states, shared by the multiplier and the divider
  typedef enum logic [1:0] {
    st_idle = 2'd0,
    st_calc = 2'd1,
    st_done = 2'd2
  } engine_state_e;

  // request as seen from the core
  typedef struct packed {
    muldiv_fn_e             fn;
    logic [tag_width-1:0]   tag;
    logic [data_width-1:0]  a;
    logic [data_width-1:0]  b;
  } muldiv_req_t;

  // response, tag travels back with the result
  typedef struct packed {
    logic [tag_width-1:0]    tag;
    logic [result_width-1:0] result;
  } muldiv_resp_t;

  // decoded request handed to the engines
  typedef struct packed {
    logic                   is_signed;
    logic [tag_width-1:0]   tag;
    logic [data_width-1:0]  a;
    logic [data_width-1:0]  b;
  } engine_req_t;

endpackage

`default_nettype wire

// File: src/muldiv_req_dispatch.sv
//------------------------------
// request dispatch
// decodes the function code and steers the request to one engine
//------------------------------
`timescale 1ns/1ps
`default_nettype none

module muldiv_req_dispatch (
  // request from the core
  input  wire logic                    req_val,
  output logic                         req_rdy,
  input  wire muldiv_pkg::muldiv_req_t req_msg,

  // per-engine handshake
  output logic                         mul_val,
  output logic                         div_val,
  input  wire logic                    mul_rdy,
  input  wire logic                    div_rdy,

  // decoded payload, shared by both engines
  output muldiv_pkg::engine_req_t      eng_req
);

  // target engine select
  logic is_mul;
  // signedness of the operation
  logic is_signed;

  //------------------------------
  // decode
  //------------------------------

  always_comb begin
    is_mul    = 1'b0;
    is_signed = 1'b0;
    case (req_msg.fn)
      muldiv_pkg::fn_mul: begin
        // multiplier always returns the signed product
        is_mul    = 1'b1;
        is_signed = 1'b1;
      end
      muldiv_pkg::fn_div_signed: begin
        is_signed = 1'b1;
      end
      // fn_div_unsigned and the unused code 3
      default: begin
        is_signed = 1'b0;
      end
    endcase
  end

  // payload goes to both, only the selected val is raised
  always_comb begin
    eng_req.is_signed = is_signed;
    eng_req.tag       = req_msg.tag;
    eng_req.a         = req_msg.a;
    eng_req.b         = req_msg.b;
  end

  //------------------------------
  // handshake steering
  //------------------------------

  assign mul_val = req_val & is_mul;
  assign div_val = req_val & ~is_mul;

  // stall only on the engine this request needs
  assign req_rdy = is_mul ? mul_rdy : div_rdy;

endmodule

`default_nettype wire

// File: src/int_mul_iterative.sv
//------------------------------
// iterative multiplier
// 32-step shift-add on magnitudes, sign applied at the output
//------------------------------
`timescale 1ns/1ps
`default_nettype none

module int_mul_iterative (
  input  wire logic                     clk,
  input  wire logic                     reset,

  input  wire logic                     req_val,
  output logic                          req_rdy,
  input  wire muldiv_pkg::engine_req_t  req_msg,

  output logic                          resp_val,
  input  wire logic                     resp_rdy,
  output muldiv_pkg::muldiv_resp_t      resp_msg
);

  muldiv_pkg::engine_state_e state;

  // operand magnitudes taken at the transfer edge
  logic [muldiv_pkg::data_width-1:0]   a_mag;
  logic [muldiv_pkg::data_width-1:0]   b_mag;
  // multiplicand shifts left, multiplier shifts right
  logic [muldiv_pkg::result_width-1:0] mcand;
  logic [muldiv_pkg::data_width-1:0]   mplier;
  logic [muldiv_pkg::result_width-1:0] prod;
  logic                                neg;
  logic [muldiv_pkg::tag_width-1:0]    tag;
  logic [muldiv_pkg::count_width-1:0]  count;

  logic accept;
  logic send;

  assign accept = req_val & req_rdy;
  assign send   = resp_val & resp_rdy;

  // magnitude of each operand when the op is signed
  assign a_mag = (req_msg.is_signed && req_msg.a[muldiv_pkg::data_width-1]) ?
                 ~req_msg.a + 1'b1 : req_msg.a;
  assign b_mag = (req_msg.is_signed && req_msg.b[muldiv_pkg::data_width-1]) ?
                 ~req_msg.b + 1'b1 : req_msg.b;

  //------------------------------
  // control
  //------------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= muldiv_pkg::st_idle;
    end else begin
      case (state)
        muldiv_pkg::st_idle: if (accept) state <= muldiv_pkg::st_calc;
        // last step runs in the cycle where count hits zero
        muldiv_pkg::st_calc: if (count == '0) state <= muldiv_pkg::st_done;
        muldiv_pkg::st_done: if (send) state <= muldiv_pkg::st_idle;
        default:             state <= muldiv_pkg::st_idle;
      endcase
    end
  end

  assign req_rdy  = (state == muldiv_pkg::st_idle);
  assign resp_val = (state == muldiv_pkg::st_done);

  //------------------------------
  // datapath
  //------------------------------

  always_ff @(posedge clk) begin
    if (accept) begin
      mcand  <= {{muldiv_pkg::data_width{1'b0}}, a_mag};
      mplier <= b_mag;
      prod   <= '0;
      // product is negative when exactly one operand is
      neg    <= req_msg.is_signed &
                (req_msg.a[muldiv_pkg::data_width-1] ^ req_msg.b[muldiv_pkg::data_width-1]);
      tag    <= req_msg.tag;
      count  <= '1;
    end else if (state == muldiv_pkg::st_calc) begin
      // add the shifted multiplicand for each set multiplier bit
      if (mplier[0]) prod <= prod + mcand;
      mcand  <= mcand << 1;
      mplier <= mplier >> 1;
      count  <= count - 1'b1;
    end
  end

  // two's complement fix-up on the way out
  always_comb begin
    resp_msg.tag    = tag;
    resp_msg.result = neg ? ~prod + 1'b1 : prod;
  end

endmodule

`default_nettype wire

// File: src/int_div_dpath.sv
//------------------------------
// divider datapath
// restoring shift-subtract with step counter and sign fix-up
//------------------------------
`timescale 1ns/1ps
`default_nettype none

module int_div_dpath (
  input  wire logic                                clk,
  input  wire logic                                reset,

  // operands straight from the request
  input  wire logic [muldiv_pkg::data_width-1:0]   a,
  input  wire logic [muldiv_pkg::data_width-1:0]   b,
  input  wire logic                                is_signed,

  // control from the FSM
  input  wire logic                                a_en,
  input  wire logic                                b_en,
  input  wire logic                                a_mux_sel,
  input  wire logic                                sub_mux_sel,
  input  wire logic                                cntr_mux_sel,
  input  wire logic                                sign_en,

  // status back to the FSM
  output logic                                     sub_neg,
  output logic                                     count_zero,

  // remainder in the high word, quotient in the low word
  output logic [muldiv_pkg::result_width-1:0]      result
);

  localparam int dw  = muldiv_pkg::data_width;
  localparam int rw  = muldiv_pkg::div_reg_width;

  // remainder/quotient and divisor registers
  logic [rw-1:0]                       a_reg;
  logic [rw-1:0]                       b_reg;
  logic [muldiv_pkg::count_width-1:0]  counter;
  logic                                quot_sign;
  logic                                rem_sign;

  logic [dw-1:0] a_mag;
  logic [dw-1:0] b_mag;
  logic [rw-1:0] a_initial;
  logic [rw-1:0] b_initial;
  logic [rw-1:0] a_shift;
  logic [rw-1:0] sub_out;
  logic [rw-1:0] step_out;
  logic [rw-1:0] a_next;
  logic [dw-1:0] quot;
  logic [dw-1:0] rem;

  //------------------------------
  // load path
  //------------------------------

  // unsigned ops pass through untouched
  assign a_mag = (is_signed && a[dw-1]) ? ~a + 1'b1 : a;
  assign b_mag = (is_signed && b[dw-1]) ? ~b + 1'b1 : b;

  // dividend low, divisor aligned to the upper word
  assign a_initial = {{(dw+1){1'b0}}, a_mag};
  assign b_initial = {1'b0, b_mag, {dw{1'b0}}};

  //------------------------------
  // one restoring step
  //------------------------------

  assign a_shift = a_reg << 1;
  assign sub_out = a_shift - b_reg;
  // guard bit set means the divisor did not fit
  assign sub_neg = sub_out[rw-1];

  // restore on a negative difference, else keep it with a quotient bit of 1
  assign step_out = sub_mux_sel ? {a_shift[rw-1:1], 1'b0} : {sub_out[rw-1:1], 1'b1};
  assign a_next   = a_mux_sel ? step_out : a_initial;

  assign count_zero = (counter == '0);

  always_ff @(posedge clk) begin
    if (reset) begin
      counter <= '1;
    end else begin
      // reload to 31 outside calc, count down inside
      counter <= cntr_mux_sel ? counter - 1'b1 : '1;
    end
  end

  always_ff @(posedge clk) begin
    if (a_en) a_reg <= a_next;
    if (b_en) b_reg <= b_initial;
    if (sign_en) begin
      // quotient follows the xor of signs, remainder follows the dividend
      quot_sign <= is_signed & (a[dw-1] ^ b[dw-1]);
      rem_sign  <= is_signed & a[dw-1];
    end
  end

  //------------------------------
  // sign fix-up
  //------------------------------

  assign quot = quot_sign ? ~a_reg[dw-1:0] + 1'b1 : a_reg[dw-1:0];
  assign rem  = rem_sign ? ~a_reg[2*dw-1:dw] + 1'b1 : a_reg[2*dw-1:dw];

  assign result = {rem, quot};

endmodule

`default_nettype wire

// File: src/int_div_iterative.sv
//------------------------------
// iterative divider
// idle/calc/done control around the restoring datapath
//------------------------------
`timescale 1ns/1ps
`default_nettype none

module int_div_iterative (
  input  wire logic                     clk,
  input  wire logic                     reset,

  input  wire logic                     req_val,
  output logic                          req_rdy,
  input  wire muldiv_pkg::engine_req_t  req_msg,

  output logic                          resp_val,
  input  wire logic                     resp_rdy,
  output muldiv_pkg::muldiv_resp_t      resp_msg
);

  muldiv_pkg::engine_state_e state;

  // datapath control
  logic a_en;
  logic b_en;
  logic a_mux_sel;
  logic sub_mux_sel;
  logic cntr_mux_sel;
  logic sign_en;
  // datapath status
  logic sub_neg;
  logic count_zero;

  logic [muldiv_pkg::result_width-1:0] result;
  logic [muldiv_pkg::tag_width-1:0]    tag;

  logic accept;
  logic send;

  assign accept = req_val & req_rdy;
  assign send   = resp_val & resp_rdy;

  int_div_dpath dpath (
    .clk          (clk),
    .reset        (reset),
    .a            (req_msg.a),
    .b            (req_msg.b),
    .is_signed    (req_msg.is_signed),
    .a_en         (a_en),
    .b_en         (b_en),
    .a_mux_sel    (a_mux_sel),
    .sub_mux_sel  (sub_mux_sel),
    .cntr_mux_sel (cntr_mux_sel),
    .sign_en      (sign_en),
    .sub_neg      (sub_neg),
    .count_zero   (count_zero),
    .result       (result)
  );

  //------------------------------
  // state register
  //------------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= muldiv_pkg::st_idle;
    end else begin
      case (state)
        muldiv_pkg::st_idle: if (accept) state <= muldiv_pkg::st_calc;
        muldiv_pkg::st_calc: if (count_zero) state <= muldiv_pkg::st_done;
        // result held here under back-pressure
        muldiv_pkg::st_done: if (send) state <= muldiv_pkg::st_idle;
        default:             state <= muldiv_pkg::st_idle;
      endcase
    end
  end

  //------------------------------
  // control outputs
  //------------------------------

  always_comb begin
    req_rdy      = 1'b0;
    resp_val     = 1'b0;
    a_en         = 1'b0;
    b_en         = 1'b0;
    a_mux_sel    = 1'b0;
    sub_mux_sel  = 1'b0;
    cntr_mux_sel = 1'b0;
    sign_en      = 1'b0;
    case (state)
      muldiv_pkg::st_idle: begin
        // load operands and signs on the transfer edge
        req_rdy = 1'b1;
        a_en    = accept;
        b_en    = accept;
        sign_en = accept;
      end
      muldiv_pkg::st_calc: begin
        a_en         = 1'b1;
        a_mux_sel    = 1'b1;
        sub_mux_sel  = sub_neg;
        cntr_mux_sel = 1'b1;
      end
      muldiv_pkg::st_done: begin
        resp_val = 1'b1;
      end
      default: begin
        req_rdy = 1'b0;
      end
    endcase
  end

  // tag rides alongside the datapath
  always_ff @(posedge clk) begin
    if (accept) tag <= req_msg.tag;
  end

  always_comb begin
    resp_msg.tag    = tag;
    resp_msg.result = result;
  end

endmodule

`default_nettype wire

// File: src/muldiv_resp_arbiter.sv
//------------------------------
// response arbiter
// round-robin merge of the multiplier and divider results
//------------------------------
`timescale 1ns/1ps
`default_nettype none

module muldiv_resp_arbiter (
  input  wire logic                      clk,
  input  wire logic                      reset,

  // engine responses
  input  wire logic                      mul_val,
  input  wire logic                      div_val,
  output logic                           mul_rdy,
  output logic                           div_rdy,
  input  wire muldiv_pkg::muldiv_resp_t  mul_msg,
  input  wire muldiv_pkg::muldiv_resp_t  div_msg,

  // merged stream to the core
  output logic                           resp_val,
  input  wire logic                      resp_rdy,
  output muldiv_pkg::muldiv_resp_t       resp_msg
);

  // 0 prefers the multiplier, 1 prefers the divider
  logic prio_div;
  logic grant_mul;
  logic grant_div;

  // non-preferred source only wins when the preferred one is idle
  assign grant_div = div_val & (prio_div | ~mul_val);
  assign grant_mul = mul_val & ~grant_div;

  // each rdy looks at the other source only, never at its own val
  assign mul_rdy = resp_rdy & (~prio_div | ~div_val);
  assign div_rdy = resp_rdy & (prio_div | ~mul_val);

  assign resp_val = mul_val | div_val;
  assign resp_msg = grant_div ? div_msg : mul_msg;

  //------------------------------
  // pointer update
  //------------------------------

  // after a transfer, prefer the source that was not served
  always_ff @(posedge clk) begin
    if (reset) begin
      prio_div <= 1'b0;
    end else if (resp_val && resp_rdy) begin
      prio_div <= grant_mul;
    end
  end

endmodule

`default_nettype wire

// File: src/int_muldiv_unit.sv
//------------------------------
// integer mul/div unit
// dispatch, two iterative engines and a response merge
//------------------------------
`timescale 1ns/1ps
`default_nettype none

module int_muldiv_unit (
  input  wire logic                      clk,
  input  wire logic                      reset,

  input  wire logic                      req_val,
  output logic                           req_rdy,
  input  wire muldiv_pkg::muldiv_req_t   req_msg,

  output logic                           resp_val,
  input  wire logic                      resp_rdy,
  output muldiv_pkg::muldiv_resp_t       resp_msg
);

  // decoded request, shared by both engines
  muldiv_pkg::engine_req_t  eng_req;

  // request side handshakes
  logic mul_req_val;
  logic mul_req_rdy;
  logic div_req_val;
  logic div_req_rdy;

  // response side streams
  logic                     mul_resp_val;
  logic                     mul_resp_rdy;
  muldiv_pkg::muldiv_resp_t mul_resp;
  logic                     div_resp_val;
  logic                     div_resp_rdy;
  muldiv_pkg::muldiv_resp_t div_resp;

  muldiv_req_dispatch dispatch (
    .req_val (req_val),
    .req_rdy (req_rdy),
    .req_msg (req_msg),
    .mul_val (mul_req_val),
    .div_val (div_req_val),
    .mul_rdy (mul_req_rdy),
    .div_rdy (div_req_rdy),
    .eng_req (eng_req)
  );

  int_mul_iterative mul (
    .clk      (clk),
    .reset    (reset),
    .req_val  (mul_req_val),
    .req_rdy  (mul_req_rdy),
    .req_msg  (eng_req),
    .resp_val (mul_resp_val),
    .resp_rdy (mul_resp_rdy),
    .resp_msg (mul_resp)
  );

  int_div_iterative div (
    .clk      (clk),
    .reset    (reset),
    .req_val  (div_req_val),
    .req_rdy  (div_req_rdy),
    .req_msg  (eng_req),
    .resp_val (div_resp_val),
    .resp_rdy (div_resp_rdy),
    .resp_msg (div_resp)
  );

  muldiv_resp_arbiter arbiter (
    .clk      (clk),
    .reset    (reset),
    .mul_val  (mul_resp_val),
    .div_val  (div_resp_val),
    .mul_rdy  (mul_resp_rdy),
    .div_rdy  (div_resp_rdy),
    .mul_msg  (mul_resp),
    .div_msg  (div_resp),
    .resp_val (resp_val),
    .resp_rdy (resp_rdy),
    .resp_msg (resp_msg)
  );

endmodule

`default_nettype wire

// File: dv/muldiv_tb_tasks.svh
//------------------------------
// mul/div testbench tasks
// driving, collecting, checking and the directed tests
//------------------------------
`ifndef muldiv_tb_tasks_svh
`define muldiv_tb_tasks_svh

// compare one value against its expected value and count the result
task automatic check(input string what, input logic [63:0] got, input logic [63:0] exp);
  checks++;
  if (got !== exp) begin
    errors++;
    $display("** Error @ %0t: %s, got %h expected %h", $time, what, got, exp);
  end
endtask

task automatic report_test(input string name, input int c0, input int e0);
  $display("test %s: %0d checks, %0d errors", name, checks - c0, errors - e0);
endtask

task automatic apply_reset();
  @(posedge clk);
  reset   <= 1'b1;
  req_val <= 1'b0;
  repeat (2) @(posedge clk);
  reset <= 1'b0;
endtask

// tags number the batch from 0
task automatic add_req(input muldiv_pkg::muldiv_fn_e fn, input logic [31:0] a,
                       input logic [31:0] b);
  muldiv_pkg::muldiv_req_t m;
  m.fn  = fn;
  m.tag = 4'(batch.size());
  m.a   = a;
  m.b   = b;
  batch.push_back(m);
endtask

// hold val and payload until the transfer edge
// rdy settles before the falling edge
task automatic send_req(input muldiv_pkg::muldiv_req_t m);
  @(posedge clk);
  req_val <= 1'b1;
  req_msg <= m;
  @(negedge clk);
  while (!req_rdy) @(negedge clk);
  // count of the cycle that ends in the transfer edge
  xfer_cycle = cycle;
  @(posedge clk);
  req_val <= 1'b0;
endtask

task automatic send_all();
  foreach (batch[i]) send_req(batch[i]);
endtask

// one random stall stretch at the start when back-pressure is on
task automatic collect_all(input bit backpressure);
  int got;
  int stall;
  got   = 0;
  stall = backpressure ? 20 + rand_bits(6) : 0;
  while (got < batch.size()) begin
    @(posedge clk);
    resp_rdy <= (stall == 0);
    @(negedge clk);
    if (resp_val && resp_rdy) begin
      if (got == 0) first_resp_cycle = cycle;
      seen[resp_msg.tag]++;
      got_result[resp_msg.tag] = resp_msg.result;
      got++;
    end
    if (stall > 0) stall--;
  end
  // nothing may follow the last response
  @(negedge clk);
  check("resp_val after last response", resp_val, 1'b0);
endtask

task automatic run_batch(input bit backpressure);
  for (int t = 0; t < 16; t++) begin
    seen[t] = 0;
  end
  fork
    send_all();
    collect_all(backpressure);
  join
  foreach (batch[i]) begin
    check($sformatf("tag %0d count", batch[i].tag), seen[batch[i].tag], 1);
    check($sformatf("tag %0d fn %0d a %h b %h", batch[i].tag, batch[i].fn, batch[i].a,
                    batch[i].b),
          got_result[batch[i].tag], ref_result(batch[i].fn, batch[i].a, batch[i].b));
  end
  batch.delete();
endtask

//------------------------------
// directed tests
//------------------------------

task automatic unsigned_div_edges();
  int c0;
  int e0;
  c0 = checks;
  e0 = errors;
  add_req(muldiv_pkg::fn_div_unsigned, 32'd0, 32'd1);
  add_req(muldiv_pkg::fn_div_unsigned, 32'd1, 32'd1);
  add_req(muldiv_pkg::fn_div_unsigned, 32'hffff_ffff, 32'd1);
  add_req(muldiv_pkg::fn_div_unsigned, 32'hffff_ffff, 32'hffff_ffff);
  // divisor larger than the dividend
  add_req(muldiv_pkg::fn_div_unsigned, 32'd5, 32'hffff_fff0);
  add_req(muldiv_pkg::fn_div_unsigned, 32'hffff_ffff, 32'd0);
  add_req(muldiv_pkg::fn_div_unsigned, 32'd100, 32'd7);
  // unused code 3
  add_req(muldiv_pkg::muldiv_fn_e'(2'd3), 32'h8000_0000, 32'd3);
  run_batch(1'b0);
  report_test("unsigned_div", c0, e0);
endtask

task automatic signed_div_signs();
  int c0;
  int e0;
  c0 = checks;
  e0 = errors;
  add_req(muldiv_pkg::fn_div_signed, 32'd7, 32'd2);
  add_req(muldiv_pkg::fn_div_signed, -32'sd7, 32'd2);
  add_req(muldiv_pkg::fn_div_signed, 32'd7, -32'sd2);
  add_req(muldiv_pkg::fn_div_signed, -32'sd7, -32'sd2);
  add_req(muldiv_pkg::fn_div_signed, 32'h8000_0000, 32'hffff_ffff);
  add_req(muldiv_pkg::fn_div_signed, 32'h8000_0000, 32'd1);
  add_req(muldiv_pkg::fn_div_signed, -32'sd7, 32'd0);
  add_req(muldiv_pkg::fn_div_signed, 32'd7, 32'd0);
  add_req(muldiv_pkg::fn_div_signed, 32'hffff_ffff, 32'h8000_0000);
  run_batch(1'b0);
  report_test("signed_div", c0, e0);
endtask

task automatic signed_mul_random();
  int          c0;
  int          e0;
  logic [31:0] a;
  logic [31:0] b;
  c0 = checks;
  e0 = errors;
  // walk all four sign pairs
  for (int i = 0; i < 10; i++) begin
    a     = rand_bits(31);
    b     = rand_bits(31);
    a[31] = i[0];
    b[31] = i[1];
    add_req(muldiv_pkg::fn_mul, a, b);
  end
  add_req(muldiv_pkg::fn_mul, 32'h8000_0000, 32'h8000_0000);
  add_req(muldiv_pkg::fn_mul, 32'hffff_ffff, 32'd1);
  run_batch(1'b0);
  report_test("signed_mul", c0, e0);
endtask

// alternate engines so both are busy together
task automatic add_mixed(input int n);
  muldiv_pkg::muldiv_fn_e fn;
  for (int i = 0; i < n; i++) begin
    fn = i[0] ? muldiv_pkg::fn_mul :
         (i[1] ? muldiv_pkg::fn_div_signed : muldiv_pkg::fn_div_unsigned);
    add_req(fn, rand_bits(32), rand_bits(i[2] ? 8 : 32));
  end
endtask

task automatic mixed_traffic();
  int c0;
  int e0;
  c0 = checks;
  e0 = errors;
  add_mixed(12);
  run_batch(1'b0);
  report_test("mixed_traffic", c0, e0);
endtask

task automatic backpressure_and_reset();
  int                      c0;
  int                      e0;
  muldiv_pkg::muldiv_req_t m;
  c0 = checks;
  e0 = errors;
  // multiply whose result will wait in done
  m.fn  = muldiv_pkg::fn_mul;
  m.tag = 4'd0;
  m.a   = 32'd3;
  m.b   = 32'd5;
  @(posedge clk);
  resp_rdy <= 1'b0;
  send_req(m);
  // second multiply while the first is still in calc
  m.tag = 4'd1;
  @(posedge clk);
  req_val <= 1'b1;
  req_msg <= m;
  @(negedge clk);
  check("req_rdy with multiplier busy", req_rdy, 1'b0);
  // a divide does not wait on the multiplier
  m.fn = muldiv_pkg::fn_div_signed;
  @(posedge clk);
  req_val <= 1'b0;
  req_msg <= m;
  @(negedge clk);
  check("req_rdy for idle divider", req_rdy, 1'b1);
  // point the payload back at the multiplier and let its result stall
  m.fn = muldiv_pkg::fn_mul;
  @(posedge clk);
  req_msg <= m;
  @(negedge clk);
  while (!resp_val) @(negedge clk);
  repeat (3) @(negedge clk);
  check("resp_val held under back-pressure", resp_val, 1'b1);
  check("held multiplier result", resp_msg.result,
        ref_result(muldiv_pkg::fn_mul, 32'd3, 32'd5));
  check("req_rdy with result held", req_rdy, 1'b0);
  apply_reset();
  @(negedge clk);
  check("resp_val after reset", resp_val, 1'b0);
  check("req_rdy after reset", req_rdy, 1'b1);
  add_mixed(8);
  run_batch(1'b1);
  report_test("backpressure_reset", c0, e0);
endtask

task automatic div_latency_single();
  int c0;
  int e0;
  c0 = checks;
  e0 = errors;
  add_req(muldiv_pkg::fn_div_unsigned, 32'd1000, 32'd7);
  run_batch(1'b0);
  check("divide latency in cycles", first_resp_cycle - xfer_cycle, div_latency);
  report_test("div_latency", c0, e0);
endtask

`endif

// File: dv/muldiv_tb.sv
//------------------------------
// mul/div unit testbench
// directed tests against a reference model of the unit
//------------------------------
`timescale 1ns/1ps
`default_nettype none

module muldiv_tb;

  // requests over all tests
  localparam int total_reqs     = 51;
  localparam int timeout_cycles = total_reqs * 40 + 400;
  // load cycle plus 32 steps
  localparam int div_latency    = 33;

  logic                     clk;
  logic                     reset;
  logic                     req_val;
  logic                     req_rdy;
  muldiv_pkg::muldiv_req_t  req_msg;
  logic                     resp_val;
  logic                     resp_rdy;
  muldiv_pkg::muldiv_resp_t resp_msg;

  // free running cycle count
  int cycle = 0;
  int checks = 0;
  int errors = 0;

  logic [31:0] lfsr_state;

  // current batch of requests and what came back per tag
  muldiv_pkg::muldiv_req_t batch[$];
  int                      seen[16];
  logic [63:0]             got_result[16];
  int                      xfer_cycle;
  int                      first_resp_cycle;

  int_muldiv_unit dut (
    .clk      (clk),
    .reset    (reset),
    .req_val  (req_val),
    .req_rdy  (req_rdy),
    .req_msg  (req_msg),
    .resp_val (resp_val),
    .resp_rdy (resp_rdy),
    .resp_msg (resp_msg)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  always @(posedge clk) begin
    cycle <= cycle + 1;
  end

  //------------------------------
  // stimulus and reference
  //------------------------------

  // galois lfsr stepped once per bit taken
  // each new bit enters at the bottom of the result
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[30:0], lfsr_state[0]};
      lfsr_state = lfsr_state[0] ? (lfsr_state >> 1) ^ 32'h8020_0003 : lfsr_state >> 1;
    end
    return v;
  endfunction

  // full signed product or remainder over quotient
  function automatic logic [63:0] ref_result(input muldiv_pkg::muldiv_fn_e fn,
                                             input logic [31:0] a, input logic [31:0] b);
    longint      sa;
    longint      sb;
    logic        sgn;
    logic [31:0] am;
    logic [31:0] bm;
    logic [31:0] q;
    logic [31:0] r;
    sa = $signed(a);
    sb = $signed(b);
    if (fn == muldiv_pkg::fn_mul) return sa * sb;
    // code 3 behaves as unsigned division
    sgn = (fn == muldiv_pkg::fn_div_signed);
    am  = (sgn && a[31]) ? -a : a;
    bm  = (sgn && b[31]) ? -b : b;
    // zero divisor gives all ones and the dividend as remainder
    if (bm == 0) begin
      q = '1;
      r = am;
    end else begin
      q = am / bm;
      r = am % bm;
    end
    // quotient truncates toward zero
    // remainder keeps the sign of the dividend
    if (sgn && (a[31] ^ b[31])) q = -q;
    if (sgn && a[31]) r = -r;
    return {r, q};
  endfunction

  `include "muldiv_tb_tasks.svh"

  //------------------------------
  // test sequence
  //------------------------------

  initial begin
    lfsr_state = 32'd32283;
    reset      = 1'b1;
    req_val    = 1'b0;
    req_msg    = '0;
    resp_rdy   = 1'b0;
    repeat (2) @(posedge clk);
    reset <= 1'b0;

    unsigned_div_edges();
    signed_div_signs();
    signed_mul_random();
    mixed_traffic();
    backpressure_and_reset();
    div_latency_single();

    $display("done: %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

  // watchdog
  initial begin
    wait (cycle >= timeout_cycles);
    $display("timeout after %0d cycles, the unit stopped responding", cycle);
    $display("STATUS: FAIL");
    $finish;
  end

endmodule

`default_nettype wire

// File: tb.f
src/muldiv_pkg.sv
src/muldiv_req_dispatch.sv
src/int_mul_iterative.sv
src/int_div_dpath.sv
src/int_div_iterative.sv
src/muldiv_resp_arbiter.sv
src/int_muldiv_unit.sv
+incdir+dv
dv/muldiv_tb.sv
